//--- Makefile
sim_bin := obj_dir/Vtb_isf

.PHONY: run clean

run: $(sim_bin)
	@out="$$(./$(sim_bin))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

$(sim_bin): compile.f $(shell cat compile.f)
	verilator --binary --timing --assert -f compile.f --top-module tb_isf

clean:
	rm -rf obj_dir

//--- compile.f
isf_pkg.sv
isf_stream_fifo.sv
isf_trigger_match.sv
isf_flow_fsm.sv
isf_stall_timer.sv
isf_egress.sv
isf_top.sv
tb_isf.sv

//--- isf_egress.sv
// ================================================
// Stream filter output stage.
// Decides every FIFO pop, holds the beat under
// back-pressure and strobes the byte count.
// ================================================

`timescale 1ns/10ps

module isf_egress (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       fifo_valid,
  input  logic                       pop_allow,
  input  logic [isf_pkg::BEAT_W-1:0]  fifo_beat,
  output logic                       fifo_pop,
  output logic                       out_tvalid,
  output logic [isf_pkg::DATA_W-1:0]  out_tdata,
  output logic [isf_pkg::STRB_W-1:0]  out_tstrb,
  output logic                       out_tlast,
  input  logic                       out_tready,
  output logic                       bytes_stb,
  output logic [isf_pkg::BYTES_W-1:0] bytes_amt
);

  logic                       out_xfer;
  logic [isf_pkg::BYTES_W-1:0] strb_cnt;

  assign out_xfer = out_tvalid && out_tready;
  assign fifo_pop = fifo_valid && pop_allow && (!out_tvalid || out_tready);

  always_comb begin
    strb_cnt = '0;
    for (int i = 0; i < isf_pkg::STRB_W; i++) begin
      strb_cnt = strb_cnt + isf_pkg::BYTES_W'(out_tstrb[i]);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_tvalid <= 1'b0;
      bytes_stb  <= 1'b0;
    end else begin
      if (fifo_pop) begin
        out_tvalid <= 1'b1;
      end else if (out_tready) begin
        out_tvalid <= 1'b0;
      end
      bytes_stb <= out_xfer;
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_pop) begin
      out_tdata <= fifo_beat[isf_pkg::DATA_W-1:0];
      out_tstrb <= fifo_beat[isf_pkg::DATA_W +: isf_pkg::STRB_W];
      out_tlast <= fifo_beat[isf_pkg::BEAT_W-1];
    end
    if (out_xfer) begin
      bytes_amt <= strb_cnt; // counted from the beat that just left.
    end
  end

  a_hold_while_stalled : assert property (
    @(posedge clk) disable iff (!arst_n)
    (out_tvalid && !out_tready) |=>
      out_tvalid && $stable({out_tdata, out_tstrb, out_tlast})
  ) else $error("output beat changed while stalled");

endmodule

//--- isf_flow_fsm.sv
// ================================================
// Flow-control FSM for the debug trigger.
// Runs freely, holds on a trigger hit and lets one
// beat through per single-step request.
// ================================================

`timescale 1ns/10ps

module isf_flow_fsm (
  input  logic clk,
  input  logic arst_n,
  input  logic trig_en,
  input  logic single_step,
  input  logic head_match,
  input  logic fifo_pop,
  output logic pop_allow,
  output logic cap_stb,
  output logic trigger_hit
);

  isf_pkg::flow_state_e state;
  isf_pkg::flow_state_e state_nxt;

  // the hit beat is popped on the same edge, so it still leaves.
  assign cap_stb     = (state == isf_pkg::ST_RUN) && fifo_pop && head_match && trig_en;
  assign pop_allow   = (state != isf_pkg::ST_HOLD);
  assign trigger_hit = (state != isf_pkg::ST_RUN);

  always_comb begin
    state_nxt = state;
    case (state)
      isf_pkg::ST_RUN: begin
        if (cap_stb) begin
          state_nxt = isf_pkg::ST_HOLD;
        end
      end
      isf_pkg::ST_HOLD: begin
        if (!trig_en) begin
          state_nxt = isf_pkg::ST_RUN;
        end else if (single_step) begin
          state_nxt = isf_pkg::ST_STEP;
        end
      end
      isf_pkg::ST_STEP: begin
        if (!trig_en) begin
          state_nxt = isf_pkg::ST_RUN;
        end else if (fifo_pop) begin
          state_nxt = isf_pkg::ST_HOLD; // one beat per step, matches are ignored.
        end
      end
      default: begin
        state_nxt = isf_pkg::ST_RUN;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= isf_pkg::ST_RUN;
    end else begin
      state <= state_nxt;
    end
  end

  // the egress stage must honour the hold.
  a_no_pop_in_hold : assert property (
    @(posedge clk) disable iff (!arst_n)
    (state == isf_pkg::ST_HOLD) |-> !fifo_pop
  ) else $error("beat released while held");

endmodule

//--- isf_pkg.sv
// ================================================
// Inbound stream filter shared definitions.
// Beat field widths and the flow-control states.
// ================================================

package isf_pkg;

  // one beat of the stream carries a data word, byte strobes and last.
  parameter int DATA_W  = 64;
  parameter int STRB_W  = DATA_W / 8;
  parameter int BEAT_W  = DATA_W + STRB_W + 1; // last sits in the top bit.
  parameter int BYTES_W = 4;                   // holds a count of 0 to 8.

  // run releases freely, hold blocks, step lets a single beat through.
  typedef enum logic [1:0] {
    ST_RUN  = 2'd0,
    ST_HOLD = 2'd1,
    ST_STEP = 2'd2
  } flow_state_e;

endpackage

//--- isf_stall_timer.sv
// ================================================
// Output stall watchdog.
// Counts consecutive back-pressured output cycles
// and pulses an interrupt when the limit is hit.
// ================================================

`timescale 1ns/10ps

module isf_stall_timer #(
  parameter int STALL_W = 16
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               out_tvalid,
  input  logic               out_tready,
  input  logic [STALL_W-1:0] stall_limit,
  output logic               stall_int
);

  logic [STALL_W-1:0] cnt;
  logic [STALL_W-1:0] cnt_inc;
  logic               stalled;
  logic               saturated;
  logic               hit;

  assign stalled   = out_tvalid && !out_tready;
  assign saturated = (cnt == '1);
  assign cnt_inc   = cnt + 1'b1;

  // the count passes the limit once per episode, so the pulse fires once.
  assign hit = stalled && !saturated && (stall_limit != '0) && (cnt_inc == stall_limit);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt       <= '0;
      stall_int <= 1'b0;
    end else begin
      if (!stalled) begin
        cnt <= '0;
      end else if (!saturated) begin
        cnt <= cnt_inc;
      end
      stall_int <= hit;
    end
  end

endmodule

//--- isf_stream_fifo.sv
// ================================================
// Stream filter beat FIFO.
// Register array with read/write pointers and an
// occupancy count. Write ready is registered.
// ================================================

`timescale 1ns/10ps

module isf_stream_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      wr_valid,
  output logic                      wr_ready,
  input  logic [isf_pkg::BEAT_W-1:0] wr_beat,
  output logic                      rd_valid,
  output logic [isf_pkg::BEAT_W-1:0] rd_beat,
  input  logic                      rd_pop
);

  localparam int AW = $clog2(FIFO_DEPTH);
  localparam int CW = AW + 1;

  logic [isf_pkg::BEAT_W-1:0] mem [FIFO_DEPTH];
  logic [AW-1:0]              wr_ptr;
  logic [AW-1:0]              rd_ptr;
  logic [CW-1:0]              count;
  logic [CW-1:0]              count_nxt;
  logic                       push;

  assign push     = wr_valid && wr_ready;
  assign rd_valid = (count != '0);
  assign rd_beat  = mem[rd_ptr];

  always_comb begin
    count_nxt = count;
    if (push && !rd_pop) begin
      count_nxt = count + 1'b1;
    end else if (!push && rd_pop) begin
      count_nxt = count - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      wr_ready <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, so it wraps by itself.
      end
      if (rd_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count    <= count_nxt;
      wr_ready <= (count_nxt != CW'(FIFO_DEPTH)); // ready looks one push ahead.
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_beat;
    end
  end

  // the egress stage must only pop a head that exists.
  a_no_pop_when_empty : assert property (
    @(posedge clk) disable iff (!arst_n)
    rd_pop |-> rd_valid
  ) else $error("fifo popped while empty");

  a_count_bound : assert property (
    @(posedge clk) disable iff (!arst_n)
    count <= CW'(FIFO_DEPTH)
  ) else $error("fifo occupancy above depth");

endmodule

//--- isf_top.sv
// ================================================
// Inbound stream filter.
// FIFO buffered 64-bit stream with a debug trigger,
// single-step, stall watchdog and byte counter.
// ================================================

`timescale 1ns/10ps

module isf_top #(
  parameter int FIFO_DEPTH = 16,
  parameter int STALL_W    = 16
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       in_tvalid,
  output logic                       in_tready,
  input  logic [isf_pkg::DATA_W-1:0]  in_tdata,
  input  logic [isf_pkg::STRB_W-1:0]  in_tstrb,
  input  logic                       in_tlast,
  output logic                       out_tvalid,
  input  logic                       out_tready,
  output logic [isf_pkg::DATA_W-1:0]  out_tdata,
  output logic [isf_pkg::STRB_W-1:0]  out_tstrb,
  output logic                       out_tlast,
  input  logic                       trig_en,
  input  logic [isf_pkg::DATA_W-1:0]  trig_mask,
  input  logic [isf_pkg::DATA_W-1:0]  trig_match,
  input  logic [STALL_W-1:0]         stall_limit,
  input  logic                       single_step,
  output logic                       trigger_hit,
  output logic [isf_pkg::DATA_W-1:0]  trig_cap_data,
  output logic                       stall_int,
  output logic                       bytes_stb,
  output logic [isf_pkg::BYTES_W-1:0] bytes_amt
);

  logic [isf_pkg::BEAT_W-1:0] in_beat;
  logic [isf_pkg::BEAT_W-1:0] fifo_beat;
  logic                       fifo_valid;
  logic                       fifo_pop;
  logic                       pop_allow;
  logic                       cap_stb;
  logic                       head_match;

  assign in_beat = {in_tlast, in_tstrb, in_tdata}; // last on top, data at the bottom.

  isf_stream_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_isf_stream_fifo (
    .clk      (clk),
    .arst_n   (arst_n),
    .wr_valid (in_tvalid),
    .wr_ready (in_tready),
    .wr_beat  (in_beat),
    .rd_valid (fifo_valid),
    .rd_beat  (fifo_beat),
    .rd_pop   (fifo_pop)
  );

  isf_trigger_match u_isf_trigger_match (
    .clk           (clk),
    .arst_n        (arst_n),
    .head_data     (fifo_beat[isf_pkg::DATA_W-1:0]),
    .trig_mask     (trig_mask),
    .trig_match    (trig_match),
    .cap_stb       (cap_stb),
    .head_match    (head_match),
    .trig_cap_data (trig_cap_data)
  );

  isf_flow_fsm u_isf_flow_fsm (
    .clk         (clk),
    .arst_n      (arst_n),
    .trig_en     (trig_en),
    .single_step (single_step),
    .head_match  (head_match),
    .fifo_pop    (fifo_pop),
    .pop_allow   (pop_allow),
    .cap_stb     (cap_stb),
    .trigger_hit (trigger_hit)
  );

  isf_stall_timer #(
    .STALL_W (STALL_W)
  ) u_isf_stall_timer (
    .clk         (clk),
    .arst_n      (arst_n),
    .out_tvalid  (out_tvalid),
    .out_tready  (out_tready),
    .stall_limit (stall_limit),
    .stall_int   (stall_int)
  );

  isf_egress u_isf_egress (
    .clk        (clk),
    .arst_n     (arst_n),
    .fifo_valid (fifo_valid),
    .pop_allow  (pop_allow),
    .fifo_beat  (fifo_beat),
    .fifo_pop   (fifo_pop),
    .out_tvalid (out_tvalid),
    .out_tdata  (out_tdata),
    .out_tstrb  (out_tstrb),
    .out_tlast  (out_tlast),
    .out_tready (out_tready),
    .bytes_stb  (bytes_stb),
    .bytes_amt  (bytes_amt)
  );

endmodule

//--- isf_trigger_match.sv
// ================================================
// Debug trigger compare and capture.
// Masked match of the FIFO head data word, with a
// register that keeps the data of the hit beat.
// ================================================

`timescale 1ns/10ps

module isf_trigger_match (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic [isf_pkg::DATA_W-1:0] head_data,
  input  logic [isf_pkg::DATA_W-1:0] trig_mask,
  input  logic [isf_pkg::DATA_W-1:0] trig_match,
  input  logic                      cap_stb,
  output logic                      head_match,
  output logic [isf_pkg::DATA_W-1:0] trig_cap_data
);

  logic [isf_pkg::DATA_W-1:0] diff;

  // only bits with a mask bit set take part in the compare.
  assign diff       = (head_data ^ trig_match) & trig_mask;
  assign head_match = (diff == '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      trig_cap_data <= '0;
    end else if (cap_stb) begin
      trig_cap_data <= head_data; // head is the beat popped on this edge.
    end
  end

endmodule

//--- tb_isf.sv
// ================================================
// Testbench for the inbound stream filter.
// Random source and sink, a queue model of the
// stream, trigger, single-step and stall checks.
// ================================================

`timescale 1ns/10ps

module tb_isf;

  localparam int N_RANDOM    = 2000;
  localparam int N_TRIG      = 20;
  localparam int N_STALL     = 3;
  localparam int N_BEATS     = N_RANDOM + N_TRIG + N_STALL;
  localparam int CLK_PERIOD  = 10;
  localparam int WATCHDOG_NS = (N_BEATS * 40 + 1000) * CLK_PERIOD;

  localparam logic [63:0] TRIG_MASK  = 64'hffff_0000_ffff_0000;
  localparam logic [63:0] TRIG_MATCH = 64'h5a3c_0000_c3a5_0000;

  logic                              clk;
  logic                              arst_n      = 1'b0;
  logic                              in_tvalid   = 1'b0;
  logic                              in_tready;
  logic [isf_pkg::DATA_W-1:0]        in_tdata    = '0;
  logic [isf_pkg::STRB_W-1:0]        in_tstrb    = '0;
  logic                              in_tlast    = 1'b0;
  logic                              out_tvalid;
  logic                              out_tready  = 1'b0;
  logic [isf_pkg::DATA_W-1:0]        out_tdata;
  logic [isf_pkg::STRB_W-1:0]        out_tstrb;
  logic                              out_tlast;
  logic                              trig_en     = 1'b0;
  logic [isf_pkg::DATA_W-1:0]        trig_mask   = '0;
  logic [isf_pkg::DATA_W-1:0]        trig_match  = '0;
  logic [15:0]                       stall_limit = 16'd3;
  logic                              single_step = 1'b0;
  logic                              trigger_hit;
  logic [isf_pkg::DATA_W-1:0]        trig_cap_data;
  logic                              stall_int;
  logic                              bytes_stb;
  logic [isf_pkg::BYTES_W-1:0]       bytes_amt;

  logic [isf_pkg::BEAT_W-1:0] exp_q [$];   // beats accepted at the input, oldest first.
  int                         errors     = 0;
  int                         checks     = 0;
  int                         sink_mode  = 0; // 0 random, 1 always ready, 2 never ready.
  int                         src_target = 0;
  int                         force_idx  = -1;
  logic                       watch_trig = 1'b0;
  int                         gen_cnt    = 0;
  int                         xfer_cnt   = 0;
  int                         int_cnt    = 0;
  int                         stall_run  = 0;
  logic                       hit_seen   = 1'b0;
  logic [63:0]                hit_data   = '0;
  logic                       amt_due    = 1'b0;
  logic [isf_pkg::BYTES_W-1:0] exp_amt   = '0;
  logic                       int_due    = 1'b0;

  isf_top i_isf_top (
    .clk           (clk),
    .arst_n        (arst_n),
    .in_tvalid     (in_tvalid),
    .in_tready     (in_tready),
    .in_tdata      (in_tdata),
    .in_tstrb      (in_tstrb),
    .in_tlast      (in_tlast),
    .out_tvalid    (out_tvalid),
    .out_tready    (out_tready),
    .out_tdata     (out_tdata),
    .out_tstrb     (out_tstrb),
    .out_tlast     (out_tlast),
    .trig_en       (trig_en),
    .trig_mask     (trig_mask),
    .trig_match    (trig_match),
    .stall_limit   (stall_limit),
    .single_step   (single_step),
    .trigger_hit   (trigger_hit),
    .trig_cap_data (trig_cap_data),
    .stall_int     (stall_int),
    .bytes_stb     (bytes_stb),
    .bytes_amt     (bytes_amt)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic end_run();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  task automatic wait_drained();
    do @(negedge clk);
    while (gen_cnt != src_target || in_tvalid || exp_q.size() != 0 || out_tvalid);
  endtask

  // one beat is sent into a blocked sink, which is released after hold cycles.
  task automatic run_stall(input logic [15:0] limit, input int hold, input int exp_pulses);
    int pulses_base;
    @(posedge clk) stall_limit <= limit;
    @(negedge clk);
    sink_mode   = 2;
    pulses_base = int_cnt;
    src_target  = src_target + 1;
    do @(negedge clk);
    while (!out_tvalid);
    repeat (hold) @(negedge clk);
    sink_mode = 1;
    wait_drained();
    check_value("stall_int pulses", 64'(int_cnt - pulses_base), 64'(exp_pulses));
  endtask

  // source, sink, output monitor and the cycle model of the strobes.
  always @(posedge clk) begin
    logic                       xfer;
    logic [isf_pkg::BEAT_W-1:0] exp_beat;
    logic [63:0]                data;
    if (arst_n) begin
      xfer = out_tvalid && out_tready;
      check_value("bytes_stb", 64'(bytes_stb), 64'(amt_due));
      if (amt_due) begin
        check_value("bytes_amt", 64'(bytes_amt), 64'(exp_amt));
      end
      amt_due = xfer;
      check_value("stall_int", 64'(stall_int), 64'(int_due));
      if (stall_int) begin
        int_cnt++;
      end
      if (out_tvalid && !out_tready) begin
        stall_run++;
        int_due = (stall_limit != '0) && (stall_run == int'(stall_limit));
      end else begin
        stall_run = 0;
        int_due   = 1'b0;
      end
      if (xfer) begin
        xfer_cnt++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Unexpected output beat at %0t with no input beat outstanding", $time);
        end else begin
          exp_beat = exp_q.pop_front();
          exp_amt  = isf_pkg::BYTES_W'($countones(exp_beat[71:64]));
          check_value("out_tdata", out_tdata, exp_beat[63:0]);
          check_value("out_tstrb", 64'(out_tstrb), 64'(exp_beat[71:64]));
          check_value("out_tlast", 64'(out_tlast), 64'(exp_beat[72]));
        end
      end
      if (!watch_trig) begin
        hit_seen = 1'b0;
      end else if (xfer && !hit_seen && ((out_tdata ^ trig_match) & trig_mask) == '0) begin
        hit_seen = 1'b1; // first beat on the output that satisfies the compare.
        hit_data = out_tdata;
      end
      if (in_tvalid && in_tready) begin
        exp_q.push_back({in_tlast, in_tstrb, in_tdata});
      end
      if (!in_tvalid || in_tready) begin
        if (gen_cnt < src_target && $urandom_range(3) != 0) begin
          data = {$urandom, $urandom};
          if (gen_cnt == force_idx) begin
            data = (data & ~trig_mask) | (trig_match & trig_mask);
          end
          in_tvalid <= 1'b1;
          in_tdata  <= data;
          in_tstrb  <= isf_pkg::STRB_W'($urandom);
          in_tlast  <= ($urandom_range(7) == 0);
          gen_cnt++;
        end else begin
          in_tvalid <= 1'b0;
        end
      end
      case (sink_mode)
        0:       out_tready <= ($urandom_range(1) == 1);
        1:       out_tready <= 1'b1;
        default: out_tready <= 1'b0;
      endcase
    end
  end

  initial begin
    int base;
    void'($urandom(32'h7c37));
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_value("in_tready", 64'(in_tready), 64'd0);
    check_value("out_tvalid", 64'(out_tvalid), 64'd0);
    check_value("trigger_hit", 64'(trigger_hit), 64'd0);
    check_value("stall_int", 64'(stall_int), 64'd0);
    check_value("bytes_stb", 64'(bytes_stb), 64'd0);
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;

    @(negedge clk);
    src_target = src_target + N_RANDOM;
    wait_drained();

    @(posedge clk);
    trig_mask  <= TRIG_MASK;
    trig_match <= TRIG_MATCH;
    trig_en    <= 1'b1;
    @(negedge clk);
    force_idx  = gen_cnt + 5;
    watch_trig = 1'b1;
    src_target = src_target + N_TRIG;
    do @(negedge clk);
    while (!hit_seen);
    base = xfer_cnt;
    repeat (50) @(negedge clk);
    check_value("beats after trigger", 64'(xfer_cnt - base), 64'd0);
    check_value("trigger_hit", 64'(trigger_hit), 64'd1);
    check_value("trig_cap_data", trig_cap_data, hit_data);

    sink_mode = 1;
    for (int k = 0; k < 4; k++) begin
      base = xfer_cnt;
      @(posedge clk) single_step <= 1'b1;
      @(posedge clk) single_step <= 1'b0;
      for (int t = 0; t < 40 && xfer_cnt == base; t++) begin
        @(negedge clk);
      end
      repeat (20) @(negedge clk);
      check_value("beats per step", 64'(xfer_cnt - base), 64'd1);
      check_value("trigger_hit", 64'(trigger_hit), 64'd1);
    end
    @(posedge clk) trig_en <= 1'b0;
    repeat (2) @(negedge clk);
    check_value("trigger_hit", 64'(trigger_hit), 64'd0);
    watch_trig = 1'b0;
    sink_mode  = 0;
    wait_drained();

    run_stall(16'd10, 15, 1);
    run_stall(16'd10, 5, 0);
    run_stall(16'd0, 30, 0);
    end_run();
  end

  initial begin
    #(WATCHDOG_NS);
    errors++;
    $display("Timeout: the run did not complete within %0d ns", WATCHDOG_NS);
    end_run();
  end

endmodule
